// File: Bender.yml
package:
  name: dcache_ctrl

sources:
  - hdl/mem_op_pkg.sv
  - hdl/dcache_pkg.sv
  - hdl/store_byte_mask.sv
  - hdl/dcache_miss_fsm.sv
  - hdl/dcache_ctrl.sv
  - target: test
    files:
      - testbench/tb_dcache_ctrl.sv

// File: filelist.f
hdl/mem_op_pkg.sv
hdl/dcache_pkg.sv
hdl/store_byte_mask.sv
hdl/dcache_miss_fsm.sv
hdl/dcache_ctrl.sv
testbench/tb_dcache_ctrl.sv

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int ADDR_WIDTH = dcache_pkg::DEFAULT_ADDR_WIDTH,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  wire                                            clk,
    input  wire                                            rstn,
    input  wire                                            rvalid,
    input  wire                                            wvalid,
    input  wire                                            wvalid_pipe,
    input  var  mem_op_pkg::mem_op_e                       mem_type_pipe,
    input  wire  [ADDR_WIDTH-1:0]                          address,
    input  wire  [dcache_pkg::NUM_WAYS-1:0]                hit,
    input  wire                                            way_sel,
    input  wire                                            write_finish,
    input  wire                                            d_arready,
    input  wire                                            d_rvalid,
    input  wire                                            d_rlast,
    output logic                                           rready,
    output logic                                           wready,
    output logic                                           d_arvalid,
    output logic [ADDR_WIDTH-1:0]                          d_araddr,
    output logic                                           d_rready,
    output logic [dcache_pkg::NUM_WAYS*LINE_BYTES-1:0]     mem_we,
    output logic [dcache_pkg::NUM_WAYS-1:0]                tag_dv_we,
    output logic                                           lru_update,
    output logic                                           miss_lru_update,
    output logic                                           miss_lru_way,
    output logic                                           wfsm_en
);

    localparam int OFF_W = $clog2(LINE_BYTES);

    // FSM to mask generator
    logic store_en;
    logic refill_en;
    logic mask_way;

    dcache_miss_fsm #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_BYTES (LINE_BYTES)
    ) u_miss_fsm (
        .clk             (clk),
        .rstn            (rstn),
        .rvalid          (rvalid),
        .wvalid          (wvalid),
        .wvalid_pipe     (wvalid_pipe),
        .address         (address),
        .hit             (hit),
        .way_sel         (way_sel),
        .write_finish    (write_finish),
        .d_arready       (d_arready),
        .d_rvalid        (d_rvalid),
        .d_rlast         (d_rlast),
        .rready          (rready),
        .wready          (wready),
        .d_arvalid       (d_arvalid),
        .d_araddr        (d_araddr),
        .d_rready        (d_rready),
        .tag_dv_we       (tag_dv_we),
        .lru_update      (lru_update),
        .miss_lru_update (miss_lru_update),
        .miss_lru_way    (miss_lru_way),
        .wfsm_en         (wfsm_en),
        .store_en        (store_en),
        .refill_en       (refill_en),
        .mask_way        (mask_way)
    );

    store_byte_mask #(
        .LINE_BYTES (LINE_BYTES)
    ) u_byte_mask (
        .store_en      (store_en),
        .refill_en     (refill_en),
        .mask_way      (mask_way),
        .mem_type_pipe (mem_type_pipe),
        .offset        (address[OFF_W-1:0]),
        .mem_we        (mem_we)
    );

endmodule

`default_nettype wire

// File: hdl/dcache_miss_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_fsm #(
    parameter int ADDR_WIDTH = dcache_pkg::DEFAULT_ADDR_WIDTH,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire                                rvalid,
    input  wire                                wvalid,
    input  wire                                wvalid_pipe,
    input  wire  [ADDR_WIDTH-1:0]              address,
    input  wire  [dcache_pkg::NUM_WAYS-1:0]    hit,
    input  wire                                way_sel,
    input  wire                                write_finish,
    input  wire                                d_arready,
    input  wire                                d_rvalid,
    input  wire                                d_rlast,
    output logic                               rready,
    output logic                               wready,
    output logic                               d_arvalid,
    output logic [ADDR_WIDTH-1:0]              d_araddr,
    output logic                               d_rready,
    output logic [dcache_pkg::NUM_WAYS-1:0]    tag_dv_we,
    output logic                               lru_update,
    output logic                               miss_lru_update,
    output logic                               miss_lru_way,
    output logic                               wfsm_en,
    output logic                               store_en,
    output logic                               refill_en,
    output logic                               mask_way
);

    localparam int OFF_W = $clog2(LINE_BYTES);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e state_next;

    logic                  any_hit;
    logic                  new_req;
    logic [ADDR_WIDTH-1:0] miss_addr;

    assign any_hit = |hit;
    assign new_req = rvalid | wvalid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= dcache_pkg::IDLE;
            miss_addr <= '0;
        end else begin
            state <= state_next;
            // Line address kept once the miss leaves lookup
            if (state == dcache_pkg::LOOKUP && !any_hit) begin
                miss_addr <= {address[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and control outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next      = state;
        rready          = 1'b0;
        wready          = 1'b0;
        d_arvalid       = 1'b0;
        d_araddr        = '0;
        d_rready        = 1'b0;
        tag_dv_we       = '0;
        lru_update      = 1'b0;
        miss_lru_update = 1'b0;
        miss_lru_way    = 1'b0;
        wfsm_en         = 1'b0;
        store_en        = 1'b0;
        refill_en       = 1'b0;
        mask_way        = 1'b0;

        case (state)
            dcache_pkg::IDLE: begin
                rready = 1'b1;
                wready = 1'b1;
                if (new_req) begin
                    state_next = dcache_pkg::LOOKUP;
                end
            end

            dcache_pkg::LOOKUP: begin
                if (any_hit) begin
                    // Completion for the request in lookup
                    rready     = ~wvalid_pipe;
                    wready     = wvalid_pipe;
                    lru_update = 1'b1;
                    store_en   = wvalid_pipe;
                    mask_way   = hit[1];
                    if (wvalid_pipe) begin
                        tag_dv_we = hit;
                    end
                    // Stay put so the next hit completes next cycle
                    state_next = new_req ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
                end else begin
                    // Kick off victim write-back alongside the refill read
                    wfsm_en    = 1'b1;
                    state_next = dcache_pkg::MISS_ADDR;
                end
            end

            dcache_pkg::MISS_ADDR: begin
                d_arvalid = 1'b1;
                d_araddr  = miss_addr;
                if (d_arready) begin
                    state_next = dcache_pkg::MISS_DATA;
                end
            end

            dcache_pkg::MISS_DATA: begin
                d_rready = 1'b1;
                if (d_rvalid && d_rlast) begin
                    state_next = dcache_pkg::REFILL;
                end
            end

            dcache_pkg::REFILL: begin
                refill_en          = 1'b1;
                mask_way           = way_sel;
                tag_dv_we[way_sel] = 1'b1;
                miss_lru_update    = 1'b1;
                miss_lru_way       = way_sel;
                state_next         = dcache_pkg::WAIT_WB;
            end

            dcache_pkg::WAIT_WB: begin
                if (write_finish) begin
                    state_next = dcache_pkg::IDLE;
                end
            end

            default: begin
                state_next = dcache_pkg::IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Tag compare never reports two matching ways
    hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        (state == dcache_pkg::LOOKUP) |-> $onehot0(hit)
    ) else $error("hit not one-hot in lookup: %b", hit);

    // Request and its address held until accepted
    ar_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (d_arvalid && !d_arready) |=> (d_arvalid && $stable(d_araddr))
    ) else $error("read address dropped or changed before d_arready");

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    // Two-way set associative, hit vector and tag enables follow this
    localparam int NUM_WAYS = 2;

    localparam int DEFAULT_ADDR_WIDTH = 32;
    localparam int DEFAULT_LINE_BYTES = 16;

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        MISS_ADDR = 3'd2,
        MISS_DATA = 3'd3,
        REFILL    = 3'd4,
        WAIT_WB   = 3'd5
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

    // Load/store access types as decoded by the pipeline
    typedef enum logic [2:0] {
        OP_LD_W  = 3'b000,
        OP_ST_W  = 3'b001,
        OP_LD_B  = 3'b010,
        OP_LD_H  = 3'b011,
        OP_LD_BU = 3'b100,
        OP_LD_HU = 3'b101,
        OP_ST_B  = 3'b110,
        OP_ST_H  = 3'b111
    } mem_op_e;

    // Bytes written by a store, zero for any load
    function automatic logic [2:0] store_bytes(input mem_op_e op);
        case (op)
            OP_ST_W: return 3'd4;
            OP_ST_H: return 3'd2;
            OP_ST_B: return 3'd1;
            default: return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/store_byte_mask.sv
`timescale 1ns/1ps
`default_nettype none

module store_byte_mask #(
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  wire                                               store_en,
    input  wire                                               refill_en,
    input  wire                                               mask_way,
    input  var  mem_op_pkg::mem_op_e                          mem_type_pipe,
    input  wire [$clog2(LINE_BYTES)-1:0]                      offset,
    output logic [dcache_pkg::NUM_WAYS*LINE_BYTES-1:0]        mem_we
);

    localparam int OFF_W  = $clog2(LINE_BYTES);

    logic [2:0]            nbytes;
    logic [OFF_W-1:0]      base;
    logic [LINE_BYTES-1:0] span;
    logic [LINE_BYTES-1:0] line_mask;

    ////////////////////////////////////////////////////////////
    // Bytes covered within one line
    ////////////////////////////////////////////////////////////

    always_comb begin
        nbytes = mem_op_pkg::store_bytes(mem_type_pipe);
        base   = offset;

        // Word stores are aligned down to the word
        if (nbytes == 3'd4) begin
            base[1:0] = 2'b00;
        end

        // Misaligned halfword writes nothing
        if (nbytes == 3'd2 && offset[0]) begin
            nbytes = 3'd0;
        end

        span = LINE_BYTES'((32'd1 << nbytes) - 32'd1);

        if (refill_en) begin
            line_mask = '1;
        end else if (store_en) begin
            line_mask = span << base;
        end else begin
            line_mask = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Place the line mask in the selected way
    ////////////////////////////////////////////////////////////

    always_comb begin
        mem_we = '0;
        mem_we[int'(mask_way)*LINE_BYTES +: LINE_BYTES] = line_mask;
    end

endmodule

`default_nettype wire

// File: testbench/tb_dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_ctrl;

    localparam int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES;
    localparam int OFF_W      = $clog2(LINE_BYTES);
    localparam int MASK_W     = dcache_pkg::NUM_WAYS * LINE_BYTES;
    localparam int WAIT_LIMIT = 40;

    logic clk, rstn, rvalid, wvalid, wvalid_pipe, way_sel, write_finish;
    logic d_arready, d_rvalid, d_rlast, rready, wready, d_arvalid, d_rready;
    logic lru_update, miss_lru_update, miss_lru_way, wfsm_en;
    logic [dcache_pkg::DEFAULT_ADDR_WIDTH-1:0] address, d_araddr, line_addr;
    logic [dcache_pkg::NUM_WAYS-1:0] hit, tag_dv_we;
    logic [MASK_W-1:0] mem_we;
    mem_op_pkg::mem_op_e mem_type_pipe;

    // Phase markers driven with the stimulus
    logic check_reset, in_lookup, in_miss;
    logic store_hit, load_hit, miss_lookup, last_beat;
    logic [6:0] idle_flags;
    logic [MASK_W+4:0] store_view, store_expect;
    logic [MASK_W+3:0] refill_view, refill_expect;
    int errors = 0;
    int timeouts = 0;
    int seed_init;

    dcache_ctrl UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_store_op(input mem_op_pkg::mem_op_e op);
        return op inside {mem_op_pkg::OP_ST_W, mem_op_pkg::OP_ST_B, mem_op_pkg::OP_ST_H};
    endfunction

    function automatic mem_op_pkg::mem_op_e random_op(input logic store);
        mem_op_pkg::mem_op_e op;
        do begin
            op = mem_op_pkg::mem_op_e'($urandom_range(7, 0));
        end while (is_store_op(op) != store);
        return op;
    endfunction

    // Byte b of way w sits at bit w * LINE_BYTES + b
    function automatic logic [MASK_W-1:0] expected_mask(input mem_op_pkg::mem_op_e op,
            input logic [OFF_W-1:0] off, input logic way, input logic refill);
        int first;
        int count;
        logic [LINE_BYTES-1:0] line;
        first = int'(off);
        count = 0;
        line  = '0;
        if (refill) begin
            first = 0;
            count = LINE_BYTES;
        end else if (op == mem_op_pkg::OP_ST_W) begin
            first = first & ~3;
            count = 4;
        end else if (op == mem_op_pkg::OP_ST_H) begin
            count = off[0] ? 0 : 2;
        end else if (op == mem_op_pkg::OP_ST_B) begin
            count = 1;
        end
        for (int b = first; b < first + count; b++) begin
            line[b] = 1'b1;
        end
        return MASK_W'(line) << (int'(way) * LINE_BYTES);
    endfunction

    assign store_hit     = in_lookup && (|hit) && wvalid_pipe;
    assign load_hit      = in_lookup && (|hit) && !wvalid_pipe;
    assign miss_lookup   = in_lookup && (hit == '0);
    assign last_beat     = d_rready && d_rvalid && d_rlast;
    assign idle_flags    = {rready, wready, |mem_we, |tag_dv_we, d_arvalid, d_rready, wfsm_en};
    assign store_view    = {mem_we, tag_dv_we, rready, wready, lru_update};
    assign store_expect  = {expected_mask(mem_type_pipe, address[OFF_W-1:0], hit[1], 1'b0),
                            hit, 3'b011};
    assign refill_view   = {mem_we, tag_dv_we, miss_lru_update, miss_lru_way};
    assign refill_expect = {expected_mask(mem_type_pipe, '0, way_sel, 1'b1),
                            2'b01 << way_sel, 1'b1, way_sel};

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    reset_state: assert property (@(posedge clk) check_reset |-> idle_flags == 7'b1100000)
        else report_mismatch("reset_state", 7'b1100000, $sampled(idle_flags));
    hit_store: assert property (@(posedge clk) disable iff (!rstn)
        store_hit |-> store_view == store_expect)
        else report_mismatch("hit_store", $sampled(store_expect), $sampled(store_view));
    hit_load: assert property (@(posedge clk) disable iff (!rstn)
        load_hit |-> store_view[MASK_W+4:0] == {{MASK_W{1'b0}}, 2'b00, 3'b101})
        else report_mismatch("hit_load", {{MASK_W{1'b0}}, 5'b00101}, $sampled(store_view));
    back_to_back: assert property (@(posedge clk) disable iff (!rstn)
        in_lookup && (|hit) && (rvalid || wvalid) |=> rready ^ wready)
        else report_mismatch("back_to_back", 1'b1, $sampled(rready ^ wready));
    miss_start: assert property (@(posedge clk) disable iff (!rstn) miss_lookup |-> wfsm_en)
        else report_mismatch("miss_start", 1'b1, $sampled(wfsm_en));
    wfsm_pulse: assert property (@(posedge clk) disable iff (!rstn) wfsm_en |=> !wfsm_en)
        else report_mismatch("wfsm_pulse", 1'b0, $sampled(wfsm_en));
    araddr_line: assert property (@(posedge clk) disable iff (!rstn)
        d_arvalid |-> d_araddr == line_addr)
        else report_mismatch("araddr_line", $sampled(line_addr), $sampled(d_araddr));
    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        d_arvalid && !d_arready |=> d_arvalid)
        else report_mismatch("ar_hold", 1'b1, $sampled(d_arvalid));
    rready_hold: assert property (@(posedge clk) disable iff (!rstn)
        d_rready && !last_beat |=> d_rready)
        else report_mismatch("rready_hold", 1'b1, $sampled(d_rready));
    refill: assert property (@(posedge clk) disable iff (!rstn)
        last_beat |=> refill_view == refill_expect)
        else report_mismatch("refill", $sampled(refill_expect), $sampled(refill_view));
    miss_no_done: assert property (@(posedge clk) disable iff (!rstn)
        in_miss |-> !rready && !wready)
        else report_mismatch("miss_no_done", 2'b00, $sampled({rready, wready}));
    finish_to_idle: assert property (@(posedge clk) disable iff (!rstn)
        write_finish |=> rready && wready)
        else report_mismatch("finish_to_idle", 2'b11, $sampled({rready, wready}));

    ////////////////////////////////////////////////////////////
    // Stimulus and memory side
    ////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_strobe();
        wvalid = 1'b1;
        step();
        wvalid = 1'b0;
    endtask

    // Chain strobes the next request in this same cycle
    task automatic drive_lookup(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                                input logic [1:0] hit_vec, input logic chain);
        mem_type_pipe = op;
        wvalid_pipe   = is_store_op(op);
        address       = addr;
        hit           = hit_vec;
        in_lookup     = 1'b1;
        wvalid        = chain;
        step();
        hit       = '0;
        in_lookup = 1'b0;
        wvalid    = 1'b0;
    endtask

    // Sampled at the falling edge, clear of the driving edge
    task automatic await_high(input logic data_phase);
        int n;
        n = 0;
        @(negedge clk);
        while (!(data_phase ? d_rready : d_arvalid) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(data_phase ? d_rready : d_arvalid)) begin
            timeouts++;
            $display("Timeout: %s never went high", data_phase ? "d_rready" : "d_arvalid");
        end
    endtask

    task automatic serve_miss(input logic [31:0] addr, input logic way);
        mem_type_pipe = random_op($urandom_range(1, 0));
        wvalid_pipe   = is_store_op(mem_type_pipe);
        address       = addr;
        line_addr     = addr & ~32'(LINE_BYTES - 1);
        way_sel       = way;
        in_lookup     = 1'b1;
        in_miss       = 1'b1;
        step();
        in_lookup = 1'b0;
        // Pipeline moves on once the miss leaves lookup
        address   = $urandom();
        repeat ($urandom_range(5, 0)) step();
        d_arready = 1'b1;
        await_high(1'b0);
        step();
        d_arready = 1'b0;
        for (int beat = 0; beat < 4; beat++) begin
            repeat ($urandom_range(5, 0)) step();
            d_rvalid = 1'b1;
            d_rlast  = (beat == 3);
            await_high(1'b1);
            step();
            d_rvalid = 1'b0;
            d_rlast  = 1'b0;
        end
        // Refill cycle, then into the write-back wait
        step();
        repeat ($urandom_range(6, 1)) step();
        write_finish = 1'b1;
        step();
        write_finish = 1'b0;
        in_miss      = 1'b0;
    endtask

    initial begin
        seed_init = $urandom(32'h9065_fdeb);
        {rstn, rvalid, wvalid, wvalid_pipe, way_sel, write_finish} = '0;
        {d_arready, d_rvalid, d_rlast, check_reset, in_lookup, in_miss} = '0;
        address       = '0;
        hit           = '0;
        mem_type_pipe = mem_op_pkg::OP_LD_W;
        repeat (8) @(posedge clk);
        #1;
        rstn        = 1'b1;
        check_reset = 1'b1;
        step();
        check_reset = 1'b0;

        // Isolated hits, stores then loads
        for (int i = 0; i < 40; i++) begin
            pulse_strobe();
            drive_lookup(random_op(i < 28), $urandom(), 2'b01 << $urandom_range(1, 0), 1'b0);
        end
        pulse_strobe();
        drive_lookup(mem_op_pkg::OP_ST_H, 32'h0000_0105, 2'b10, 1'b0);

        pulse_strobe();
        for (int i = 0; i < 12; i++) begin
            drive_lookup(random_op($urandom_range(1, 0)), $urandom(),
                         2'b01 << $urandom_range(1, 0), i < 11);
        end

        for (int i = 0; i < 4; i++) begin
            pulse_strobe();
            serve_miss($urandom(), $urandom_range(1, 0));
        end
        repeat (3) step();

        $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
